//--- dv/stimInput.txt
# columns: fetchInstr(hex) takeBranch predictTaken expPcEnable expFlushIfId expMispredict
# one line per clock cycle, a held PC repeats the same fetch word on the next line
00100093 0 0 1 0 0
00200113 0 0 1 0 0
00300193 0 0 1 0 0
# lw x5 then add reading x5 stalls once
0000A283 0 0 1 0 0
00228433 0 0 0 1 0
00228433 0 0 1 0 0
# load to x0 and a store with rd field 5 do not stall
0000A003 0 0 1 0 0
000004B3 0 0 1 0 0
0020A2A3 0 0 1 0 0
00028533 0 0 1 0 0
# addi x6 then beq on x6 stalls once
00600313 0 0 1 0 0
00030463 0 0 0 1 0
00030463 0 0 1 0 0
# lw x7, one gap, then jalr on x7 stalls while the load is in execute
0000A383 0 0 1 0 0
00300193 0 0 1 0 0
00038067 0 0 0 1 0
00038067 0 0 1 0 0
# agreeing prediction, then a misprediction on top of a load-use hazard
00100093 1 1 1 0 0
0000A283 0 0 1 0 0
00228433 1 0 1 1 1
00200113 0 1 1 1 1
# ecall holds the PC until a misprediction redirects
00000073 0 0 0 0 0
00000073 0 0 0 0 0
00000073 1 0 1 1 1
00300193 0 0 1 0 0
00000013 0 0 1 0 0

//--- hazardSub.f
design/hazardPkg.sv
design/stageInfoIf.sv
design/loadUseCheck.sv
design/controlUseCheck.sv
design/hazardDetect.sv
design/stageTracker.sv
design/hazardTop.sv
dv/hazardTop_asserts.sv
dv/hazardTb.sv

//--- Makefile
# Verilator build and run of the hazard-control testbench
TOP = hazardTb
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the simulation and check $(LOG)"
	@echo "  clean  remove obj_dir and $(LOG)"
	@echo "  help   show this list"

obj_dir/V$(TOP): hazardSub.f design/*.sv dv/*.sv
	verilator --binary --timing --assert --top-module $(TOP) -f hazardSub.f

test: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "test failed" $(LOG) || [ $$status -ne 0 ]; then \
		echo "FAIL"; exit 1; \
	fi; \
	echo "PASS"

clean:
	rm -rf obj_dir $(LOG)

//--- dv/hazardTb.sv
`timescale 1ns/1ps

// drives the hazard-control top level from the stimulus file and checks it every cycle
module hazardTb;

	// upper bounds for the two waiting loops, in clock cycles and in file lines
	localparam int resetTimeout = 20;
	localparam int lineLimit = 500;

	logic clk;
	logic rst;
	hazardPkg::instrT fetchInstr;
	logic takeBranch;
	logic predictTaken;
	logic pcEnable;
	logic flushIfId;
	logic mispredict;
	hazardPkg::instrT idInstr;
	hazardPkg::instrT exInstr;

	// reference copy of the decode and execute stage registers
	hazardPkg::instrT idModel;
	hazardPkg::instrT exModel;

	hazardTop dut_i (
		.clk(clk),
		.rst(rst),
		.fetchInstr(fetchInstr),
		.takeBranch(takeBranch),
		.predictTaken(predictTaken),
		.pcEnable(pcEnable),
		.flushIfId(flushIfId),
		.mispredict(mispredict),
		.idInstr(idInstr),
		.exInstr(exInstr)
	);

	always #5 clk = ~clk;

	// prints the reason, then the fail message, and ends the run
	task automatic abortRun(string reason);
		$display("ERROR: %s", reason);
		$display("test failed");
		$fatal(1, "simulation aborted");
	endtask

	task automatic checkFlag(string name, logic expected, logic actual);
		if (actual !== expected) begin
			$display("MISMATCH time=%0t %s expected=%b actual=%b", $time, name, expected, actual);
			abortRun("a flag differs from the stimulus file");
		end
	endtask

	task automatic checkInstr(string name, hazardPkg::instrT expected, hazardPkg::instrT actual);
		if (actual !== expected) begin
			$display("MISMATCH time=%0t %s expected=%h actual=%h", $time, name, expected, actual);
			abortRun("a stage register differs from the reference model");
		end
	endtask

	// what decode takes at the next edge, a flush turns the fetched word into a bubble
	function automatic hazardPkg::instrT decodeNext(hazardPkg::instrT fetched, logic flush);
		return flush ? hazardPkg::nopInstr : fetched;
	endfunction

	// idle values on every input, then two cycles of reset
	initial begin
		clk = 1'b0;
		rst = 1'b1;
		fetchInstr = hazardPkg::nopInstr;
		takeBranch = 1'b0;
		predictTaken = 1'b0;
		repeat (2) @(posedge clk);
		#1;
		rst = 1'b0;
	end

	initial begin
		int fd;
		int waited;
		int lineCount;
		int vectorCount;
		int fields;
		string line;
		hazardPkg::instrT stimInstr;
		hazardPkg::instrT heldInstr;
		logic holdActive;
		logic stimTake;
		logic stimPredict;
		logic expPc;
		logic expFlush;
		logic expMis;

		// leaves the loop on the first rising edge with reset low
		waited = 0;
		while (rst !== 1'b0) begin
			if (waited == resetTimeout)
				abortRun("reset was not released within the expected number of cycles");
			@(posedge clk);
			waited++;
		end

		// both stages hold a NOP right after reset, and decode has just taken the idle NOP
		idModel = hazardPkg::nopInstr;
		exModel = hazardPkg::nopInstr;
		heldInstr = hazardPkg::nopInstr;
		holdActive = 1'b0;

		fd = $fopen("dv/stimInput.txt", "r");
		if (fd == 0)
			abortRun("cannot open the stimulus file dv/stimInput.txt");

		lineCount = 0;
		vectorCount = 0;
		while ($fgets(line, fd) != 0) begin
			lineCount++;
			if (lineCount > lineLimit)
				abortRun("the stimulus file did not end within the line limit");
			// lines that start with a hash sign are comments
			if ((line.len() > 0) && (line.getc(0) == 8'h23))
				continue;
			fields = $sscanf(line, "%h %b %b %b %b %b", stimInstr, stimTake, stimPredict,
				expPc, expFlush, expMis);
			if (fields <= 0)
				continue;
			if (fields != 6)
				abortRun("a line of the stimulus file does not hold six fields");
			// the environment must keep its word while the PC is held
			if (holdActive && (stimInstr !== heldInstr))
				abortRun("the stimulus file changes the fetched word while the PC is held");

			#1;
			fetchInstr = stimInstr;
			takeBranch = stimTake;
			predictTaken = stimPredict;

			// flags are combinational, so the falling edge sees them settled
			@(negedge clk);
			checkFlag("pcEnable", expPc, pcEnable);
			checkFlag("flushIfId", expFlush, flushIfId);
			checkFlag("mispredict", expMis, mispredict);
			checkInstr("idInstr", idModel, idInstr);
			checkInstr("exInstr", exModel, exInstr);

			exModel = idModel;
			idModel = decodeNext(stimInstr, expFlush);
			holdActive = !expPc;
			heldInstr = stimInstr;
			vectorCount++;
			@(posedge clk);
		end
		$fclose(fd);

		if (vectorCount == 0) begin
			abortRun("the stimulus file holds no vectors");
		end else begin
			$display("test passed");
			$finish;
		end
	end

endmodule

//--- dv/hazardTop_asserts.sv
`timescale 1ns/1ps

// checks on the hazard-control top level, attached to every hazardTop through bind
module hazardTop_asserts (
	input logic clk,
	input logic rst,
	input hazardPkg::instrT fetchInstr,
	input logic pcEnable,
	input logic flushIfId,
	input logic mispredict,
	input hazardPkg::instrT idInstr
);

	// a redirect always loads the new PC
	mispredictLoadsPc: assert property (
		@(posedge clk) disable iff (rst)
		mispredict |-> pcEnable
	) else $error("mispredict is high while pcEnable is low");

	// outside an ecall a held PC comes from a hazard, and every hazard inserts a bubble
	stallFlushes: assert property (
		@(posedge clk) disable iff (rst)
		(!pcEnable && !mispredict && (fetchInstr != hazardPkg::ecallInstr)) |-> flushIfId
	) else $error("the PC is held for a hazard but flushIfId is low");

	// a flushed fetch turns into a NOP in decode one cycle later
	flushGivesNop: assert property (
		@(posedge clk) disable iff (rst)
		flushIfId |=> (idInstr == hazardPkg::nopInstr)
	) else $error("decode does not hold a NOP after a flush");

endmodule

bind hazardTop hazardTop_asserts asserts_i (
	.clk(clk),
	.rst(rst),
	.fetchInstr(fetchInstr),
	.pcEnable(pcEnable),
	.flushIfId(flushIfId),
	.mispredict(mispredict),
	.idInstr(idInstr)
);

//--- design/hazardTop.sv
`timescale 1ns/1ps
`default_nettype none

// hazard control for the five-stage pipeline, stage tracking plus the hazard unit
module hazardTop #(
	// passed down to the stage tracker
	parameter bit trackNops = 1'b1
) (
	input logic clk,
	input logic rst,
	// held steady by the environment while pcEnable is low
	input hazardPkg::instrT fetchInstr,
	// later-stage branch outcome
	input logic takeBranch,
	// prediction that fetch followed
	input logic predictTaken,
	output logic pcEnable,
	output logic flushIfId,
	output logic mispredict,
	// contents of the two tracked stage registers
	output hazardPkg::instrT idInstr,
	output hazardPkg::instrT exInstr
);

	// decode and execute stage views shared by the tracker and the hazard unit
	stageInfoIf idStage ();
	stageInfoIf exStage ();

	stageTracker #(
		.trackNops(trackNops)
	) tracker (
		.clk(clk),
		.rst(rst),
		.fetchInstr(fetchInstr),
		.flushIfId(flushIfId),
		.idStage(idStage),
		.exStage(exStage)
	);

	hazardDetect hazardUnit (
		.fetchInstr(fetchInstr),
		.takeBranch(takeBranch),
		.predictTaken(predictTaken),
		.idStage(idStage),
		.exStage(exStage),
		.pcEnable(pcEnable),
		.flushIfId(flushIfId),
		.mispredict(mispredict)
	);

	assign idInstr = idStage.instr;
	assign exInstr = exStage.instr;

endmodule

`default_nettype wire

//--- design/stageTracker.sv
`timescale 1ns/1ps
`default_nettype none

// the decode and execute stage registers as far as hazard detection cares
// each stage keeps its instruction plus the write and load flags derived from it
module stageTracker #(
	// 1 marks an inserted bubble as not valid, 0 keeps it counted as valid
	parameter bit trackNops = 1'b1
) (
	input logic clk,
	input logic rst,
	// the instruction currently being fetched
	input hazardPkg::instrT fetchInstr,
	// from the hazard unit, puts a NOP into decode instead of the fetched word
	input logic flushIfId,
	// IF/ID to ID/EX register
	stageInfoIf.owner idStage,
	// ID/EX to EX/MEM register
	stageInfoIf.owner exStage
);

	// what decode loads at the coming edge
	hazardPkg::instrT idNextInstr;
	hazardPkg::opcodeT idNextOp;
	logic idNextRegWrite;
	logic idNextMemRead;
	logic idNextValid;

	// a flush means the fetched word must not enter the pipeline
	assign idNextInstr = flushIfId ? hazardPkg::nopInstr : fetchInstr;
	assign idNextOp = hazardPkg::opOf(idNextInstr);

	// flags are worked out once here so no checker has to decode opcodes for them
	assign idNextRegWrite = hazardPkg::writesRd(idNextOp);
	assign idNextMemRead = (idNextOp == hazardPkg::opLoad);

	// a bubble carries no producer when nops are tracked
	assign idNextValid = trackNops ? !flushIfId : 1'b1;

	// decode register, refilled every cycle
	always_ff @(posedge clk) begin
		if (rst) begin
			idStage.instr <= hazardPkg::nopInstr;
			idStage.regWrite <= 1'b0;
			idStage.memRead <= 1'b0;
			idStage.valid <= 1'b0;
		end else begin
			idStage.instr <= idNextInstr;
			idStage.regWrite <= idNextRegWrite;
			idStage.memRead <= idNextMemRead;
			idStage.valid <= idNextValid;
		end
	end

	// execute register, a plain one-cycle copy of decode
	// bubbles travel along with their flags so they never match later
	always_ff @(posedge clk) begin
		if (rst) begin
			exStage.instr <= hazardPkg::nopInstr;
			exStage.regWrite <= 1'b0;
			exStage.memRead <= 1'b0;
			exStage.valid <= 1'b0;
		end else begin
			exStage.instr <= idStage.instr;
			exStage.regWrite <= idStage.regWrite;
			exStage.memRead <= idStage.memRead;
			exStage.valid <= idStage.valid;
		end
	end

endmodule

`default_nettype wire

//--- design/hazardDetect.sv
`timescale 1ns/1ps
`default_nettype none

// turns the raw hazard checks into the PC enable and the IF/ID flush
// everything here is combinational, the flags follow the inputs in the same cycle
module hazardDetect (
	// the instruction currently being fetched
	input hazardPkg::instrT fetchInstr,
	// branch outcome from the stage that resolves branches
	input logic takeBranch,
	// the prediction that fetch followed for that branch
	input logic predictTaken,
	// decode stage register
	stageInfoIf.observer idStage,
	// execute stage register
	stageInfoIf.observer exStage,
	// goes straight to the PC register enable
	output logic pcEnable,
	// replaces the next decode entry with a NOP
	output logic flushIfId,
	// the followed prediction was wrong
	output logic mispredict
);

	// one flag per kind of read-after-write hazard
	logic loadUseStall;
	logic aluBranchStall;
	logic loadBranchStall;

	// any hazard at all
	logic stall;

	// ecall waits in fetch until the environment handles it
	logic ecallInFetch;

	// load in decode feeding any fetched instruction
	loadUseCheck loadUse (
		.fetchInstr(fetchInstr),
		.idStage(idStage),
		.stall(loadUseStall)
	);

	// any writer in decode feeding a fetched branch or jalr
	controlUseCheck #(
		.loadOnly(1'b0)
	) aluToBranch (
		.fetchInstr(fetchInstr),
		.downStage(idStage),
		.stall(aluBranchStall)
	);

	// a load in execute feeding a fetched branch or jalr
	controlUseCheck #(
		.loadOnly(1'b1)
	) loadToBranch (
		.fetchInstr(fetchInstr),
		.downStage(exStage),
		.stall(loadBranchStall)
	);

	assign stall = loadUseStall || aluBranchStall || loadBranchStall;

	// the whole word is compared so that other system instructions do not match
	assign ecallInFetch = (fetchInstr == hazardPkg::ecallInstr);

	// a disagreement in either direction means fetch went down the wrong path
	assign mispredict = (takeBranch != predictTaken);

	// a redirect has to load the new PC even if the wrong-path instruction had a hazard
	assign pcEnable = mispredict || !(stall || ecallInFetch);

	// on a redirect the fetched word is wrong-path, on a stall a bubble goes in while fetch waits
	// an ecall alone only holds the PC and lets decode keep the same word
	assign flushIfId = mispredict || stall;

endmodule

`default_nettype wire

//--- design/controlUseCheck.sv
`timescale 1ns/1ps
`default_nettype none

// catches a branch or jalr in fetch that reads a register still being produced further down
// branches resolve early, so they cannot wait for the normal forwarding paths
module controlUseCheck #(
	// 0 counts any register writer, 1 counts loads only
	parameter bit loadOnly = 1'b0
) (
	// the instruction currently being fetched
	input hazardPkg::instrT fetchInstr,
	// the stage register that may hold the producer
	stageInfoIf.observer downStage,
	// high when fetch has to wait
	output logic stall
);

	// fields of the fetched instruction
	hazardPkg::opcodeT fetchOp;
	hazardPkg::regAddrT fetchRs1;
	hazardPkg::regAddrT fetchRs2;

	// destination of the instruction further down the pipeline
	hazardPkg::regAddrT downRd;

	// the down stage writes a register of the kind this instance cares about
	logic writerKind;
	logic producerLive;

	// fetched instruction is a consumer that resolves early
	logic fetchIsControl;

	// per-source match, qualified by whether the source is really read
	logic rs1Hit;
	logic rs2Hit;

	assign fetchOp = hazardPkg::opOf(fetchInstr);
	assign fetchRs1 = hazardPkg::rs1Of(fetchInstr);
	assign fetchRs2 = hazardPkg::rs2Of(fetchInstr);
	assign downRd = hazardPkg::rdOf(downStage.instr);

	assign fetchIsControl = hazardPkg::isControl(fetchOp);

	// in execute, an ALU result can already be forwarded, only a memory value is too late
	assign writerKind = loadOnly ? downStage.memRead : downStage.regWrite;

	// x0 is never a real producer
	assign producerLive = downStage.valid && writerKind && (downRd != '0);

	// jalr reads rs1 only, a branch reads both
	assign rs1Hit = hazardPkg::usesRs1(fetchOp) && (fetchRs1 == downRd);
	assign rs2Hit = hazardPkg::usesRs2(fetchOp) && (fetchRs2 == downRd);

	assign stall = fetchIsControl && producerLive && (rs1Hit || rs2Hit);

endmodule

`default_nettype wire

//--- design/loadUseCheck.sv
`timescale 1ns/1ps
`default_nettype none

// catches a load in decode whose result the fetched instruction needs right away
// the loaded value shows up too late for forwarding into execute, so one bubble is required
module loadUseCheck (
	// the instruction currently being fetched
	input hazardPkg::instrT fetchInstr,
	// the decode stage register
	stageInfoIf.observer idStage,
	// high when fetch has to wait one cycle
	output logic stall
);

	// fields of the fetched instruction
	hazardPkg::opcodeT fetchOp;
	hazardPkg::regAddrT fetchRs1;
	hazardPkg::regAddrT fetchRs2;

	// destination of the instruction in decode
	hazardPkg::regAddrT idRd;

	// per-source match, already qualified by whether the source is really read
	logic rs1Hit;
	logic rs2Hit;

	// decode stage holds a load that actually produces a register value
	logic producerLive;

	assign fetchOp = hazardPkg::opOf(fetchInstr);
	assign fetchRs1 = hazardPkg::rs1Of(fetchInstr);
	assign fetchRs2 = hazardPkg::rs2Of(fetchInstr);
	assign idRd = hazardPkg::rdOf(idStage.instr);

	// writes to x0 are discarded, so they can never create a dependency
	assign producerLive = idStage.valid && idStage.memRead && (idRd != '0);

	// an immediate field that happens to look like a register index is not a real read
	assign rs1Hit = hazardPkg::usesRs1(fetchOp) && (fetchRs1 == idRd);
	assign rs2Hit = hazardPkg::usesRs2(fetchOp) && (fetchRs2 == idRd);

	assign stall = producerLive && (rs1Hit || rs2Hit);

endmodule

`default_nettype wire

//--- design/stageInfoIf.sv
`timescale 1ns/1ps
`default_nettype none

// what the hazard logic needs to know about one pipeline stage register
interface stageInfoIf;

	// the instruction word held by this stage
	hazardPkg::instrT instr;
	// set when the held instruction writes its rd
	logic regWrite;
	// set when the held instruction is a load
	logic memRead;
	// cleared out of reset and, optionally, for inserted bubbles
	logic valid;

	// the stage register itself drives all fields
	modport owner (output instr, regWrite, memRead, valid);

	// checkers only look at the stage
	modport observer (input instr, regWrite, memRead, valid);

endinterface

`default_nettype wire

//--- design/hazardPkg.sv
package hazardPkg;

	// one full instruction word as fetched from memory
	typedef logic [31:0] instrT;
	// architectural register index, x0 through x31
	typedef logic [4:0] regAddrT;
	// major opcode held in the low seven bits of every instruction
	typedef logic [6:0] opcodeT;

	// base RV32I major opcodes that the hazard logic needs to tell apart
	localparam opcodeT opLoad = 7'b0000011;
	localparam opcodeT opBranch = 7'b1100011;
	localparam opcodeT opJalr = 7'b1100111;
	localparam opcodeT opJal = 7'b1101111;
	localparam opcodeT opLui = 7'b0110111;
	localparam opcodeT opAuipc = 7'b0010111;
	localparam opcodeT opOpImm = 7'b0010011;
	localparam opcodeT opOp = 7'b0110011;
	localparam opcodeT opStore = 7'b0100011;
	localparam opcodeT opSystem = 7'b1110011;

	// addi x0,x0,0 is the bubble that a flush drops into decode
	localparam instrT nopInstr = {12'd0, 5'd0, 3'b000, 5'd0, opOpImm};
	// ecall has every field but the opcode at zero
	localparam instrT ecallInstr = {25'd0, opSystem};

	function automatic opcodeT opOf(instrT instr);
		return instr[6:0];
	endfunction

	function automatic regAddrT rdOf(instrT instr);
		return instr[11:7];
	endfunction

	function automatic regAddrT rs1Of(instrT instr);
		return instr[19:15];
	endfunction

	function automatic regAddrT rs2Of(instrT instr);
		return instr[24:20];
	endfunction

	// the rs1 field is a real operand for these formats only, in the others it holds immediate bits
	function automatic logic usesRs1(opcodeT op);
		return (op == opBranch) || (op == opJalr) || (op == opLoad) ||
			(op == opStore) || (op == opOpImm) || (op == opOp);
	endfunction

	// only R, S and B formats carry a second source register
	function automatic logic usesRs2(opcodeT op);
		return (op == opBranch) || (op == opStore) || (op == opOp);
	endfunction

	// stores and branches leave rd unused; system is treated as non-writing here
	function automatic logic writesRd(opcodeT op);
		return (op == opLoad) || (op == opJalr) || (op == opJal) || (op == opLui) ||
			(op == opAuipc) || (op == opOpImm) || (op == opOp);
	endfunction

	// instructions resolved early in the pipeline, jal needs no register so it is not included
	function automatic logic isControl(opcodeT op);
		return (op == opBranch) || (op == opJalr);
	endfunction

endpackage
